/* verilog/exec_pkg.sv */
package exec_pkg;

	// register data and data memory byte address
	localparam int DATA_WIDTH = 32;
	localparam int MEM_ADDR_WIDTH = 10;

	// bus cycles allowed without ack before abort
	localparam int BUS_TIMEOUT_CYCLES = 16;
	// counter wide enough to reach timeout minus one
	localparam int TIMER_WIDTH = $clog2(BUS_TIMEOUT_CYCLES);

	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [MEM_ADDR_WIDTH-1:0] addr_t;
	// one bit per byte lane
	typedef logic [3:0] sel_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [3:0] {
		LSU_NONE,
		LSU_LB,
		LSU_LH,
		LSU_LW,
		LSU_LBU,
		LSU_LHU,
		LSU_SB,
		LSU_SH,
		LSU_SW
	} lsu_op_e;

	// zero/nonzero look at the alu result, so sub/slt/sltu pick the compare
	typedef enum logic [2:0] {
		BR_NONE,
		BR_JAL,
		BR_JALR,
		BR_ZERO,
		BR_NONZERO
	} br_op_e;

	// alu operand sources
	typedef enum logic [1:0] {
		ORIG_REGS,
		ORIG_RS1_IMM,
		ORIG_PC_IMM
	} origin_e;

	// write-back source
	typedef enum logic [1:0] {
		TGT_ALU,
		TGT_MEM,
		TGT_PC_4,
		TGT_CSR
	} target_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_EXEC,
		ST_BUS,
		ST_RESP
	} exec_state_e;

	// decoded operation from the issuer
	typedef struct packed {
		alu_op_e alu_op;
		lsu_op_e lsu_op;
		br_op_e br_op;
		origin_e origin;
		target_e target;
		data_t rs1;
		data_t rs2;
		data_t imm;
		data_t pc;
		data_t csr_val;
	} exec_op_t;

	typedef struct packed {
		data_t rd_val;
		data_t next_pc;
		logic taken;
		logic bus_err;
	} exec_res_t;

	// wishbone classic, master-driven side
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		addr_t adr;
		data_t dat;
		sel_t sel;
	} wb_req_t;

endpackage

/* verilog/exec_alu.sv */
`timescale 1ns/1ps

module exec_alu (
	input exec_pkg::alu_op_e alu_op_i,
	input exec_pkg::data_t a_i,
	input exec_pkg::data_t b_i,
	output exec_pkg::data_t result_o,
	output logic zero_o
);

	// rv32 shifts only look at five bits
	logic [4:0] shamt;

	assign shamt = b_i[4:0];

	always_comb begin
		result_o = '0;
		case (alu_op_i)
			exec_pkg::ALU_ADD: result_o = a_i + b_i;
			exec_pkg::ALU_SUB: result_o = a_i - b_i;
			exec_pkg::ALU_SLL: result_o = a_i << shamt;
			// compares give 0 or 1 in bit 0
			exec_pkg::ALU_SLT: result_o = {31'd0, $signed(a_i) < $signed(b_i)};
			exec_pkg::ALU_SLTU: result_o = {31'd0, a_i < b_i};
			exec_pkg::ALU_XOR: result_o = a_i ^ b_i;
			exec_pkg::ALU_SRL: result_o = a_i >> shamt;
			// arithmetic shift keeps the sign
			exec_pkg::ALU_SRA: result_o = $signed(a_i) >>> shamt;
			exec_pkg::ALU_OR: result_o = a_i | b_i;
			exec_pkg::ALU_AND: result_o = a_i & b_i;
			// lui style, operand b straight through
			exec_pkg::ALU_PASS_B: result_o = b_i;
			default: result_o = '0;
		endcase
	end

	// branch compare flag
	assign zero_o = (result_o == '0);

endmodule

/* verilog/exec_lsu.sv */
`timescale 1ns/1ps

module exec_lsu (
	input exec_pkg::lsu_op_e lsu_op_i,
	input exec_pkg::data_t addr_i,
	input exec_pkg::data_t store_val_i,
	input exec_pkg::data_t load_word_i,
	output exec_pkg::addr_t adr_o,
	output exec_pkg::data_t store_dat_o,
	output exec_pkg::sel_t sel_o,
	output logic we_o,
	output logic access_o,
	output logic misaligned_o,
	output exec_pkg::data_t load_val_o
);

	logic [1:0] offset;
	// load word moved down to the addressed byte
	exec_pkg::data_t shifted;

	assign offset = addr_i[1:0];
	// word aligned, low bits of the alu address only
	assign adr_o = {addr_i[exec_pkg::MEM_ADDR_WIDTH-1:2], 2'b00};
	assign shifted = load_word_i >> {offset, 3'b000};

	assign access_o = (lsu_op_i != exec_pkg::LSU_NONE);
	assign we_o = (lsu_op_i == exec_pkg::LSU_SB) || (lsu_op_i == exec_pkg::LSU_SH) ||
		(lsu_op_i == exec_pkg::LSU_SW);

	always_comb begin
		sel_o = '0;
		store_dat_o = store_val_i;
		load_val_o = '0;
		misaligned_o = 1'b0;
		case (lsu_op_i)
			exec_pkg::LSU_LB, exec_pkg::LSU_LBU, exec_pkg::LSU_SB: begin
				sel_o = 4'b0001 << offset;
				// byte repeated in every lane, sel picks one
				store_dat_o = {4{store_val_i[7:0]}};
			end
			exec_pkg::LSU_LH, exec_pkg::LSU_LHU, exec_pkg::LSU_SH: begin
				sel_o = offset[1] ? 4'b1100 : 4'b0011;
				store_dat_o = {2{store_val_i[15:0]}};
				misaligned_o = offset[0];
			end
			exec_pkg::LSU_LW, exec_pkg::LSU_SW: begin
				sel_o = 4'b1111;
				misaligned_o = (offset != 2'b00);
			end
			default: sel_o = '0;
		endcase
		// sign or zero extension of the loaded value
		case (lsu_op_i)
			exec_pkg::LSU_LB: load_val_o = {{24{shifted[7]}}, shifted[7:0]};
			exec_pkg::LSU_LBU: load_val_o = {24'd0, shifted[7:0]};
			exec_pkg::LSU_LH: load_val_o = {{16{shifted[15]}}, shifted[15:0]};
			exec_pkg::LSU_LHU: load_val_o = {16'd0, shifted[15:0]};
			exec_pkg::LSU_LW: load_val_o = load_word_i;
			default: load_val_o = '0;
		endcase
	end

endmodule

/* verilog/exec_branch.sv */
`timescale 1ns/1ps

module exec_branch (
	input exec_pkg::br_op_e br_op_i,
	input exec_pkg::data_t pc_i,
	input exec_pkg::data_t imm_i,
	input exec_pkg::data_t alu_result_i,
	input logic alu_zero_i,
	output exec_pkg::data_t pc_4_o,
	output exec_pkg::data_t next_pc_o,
	output logic taken_o
);

	exec_pkg::data_t target;

	// return address and fall-through
	assign pc_4_o = pc_i + 32'd4;

	always_comb begin
		taken_o = 1'b0;
		// pc relative by default, jal and conditional branches
		target = pc_i + imm_i;
		case (br_op_i)
			exec_pkg::BR_JAL: taken_o = 1'b1;
			exec_pkg::BR_JALR: begin
				taken_o = 1'b1;
				// alu holds rs1 + imm, lsb forced low
				target = {alu_result_i[31:1], 1'b0};
			end
			exec_pkg::BR_ZERO: taken_o = alu_zero_i;
			exec_pkg::BR_NONZERO: taken_o = !alu_zero_i;
			default: taken_o = 1'b0;
		endcase
	end

	assign next_pc_o = taken_o ? target : pc_4_o;

endmodule

/* verilog/exec_datapath.sv */
`timescale 1ns/1ps

module exec_datapath (
	input exec_pkg::exec_op_t op_i,
	input exec_pkg::data_t load_word_i,
	input logic bus_err_i,
	output exec_pkg::addr_t wb_adr_o,
	output exec_pkg::data_t wb_dat_o,
	output exec_pkg::sel_t wb_sel_o,
	output logic wb_we_o,
	output logic access_o,
	output logic misaligned_o,
	output exec_pkg::exec_res_t res_o
);

	exec_pkg::data_t s1_alu;
	exec_pkg::data_t s2_alu;
	exec_pkg::data_t alu_res;
	logic alu_zero;
	exec_pkg::data_t mem_val;
	exec_pkg::data_t pc_4;
	exec_pkg::data_t next_pc;
	logic taken;
	exec_pkg::data_t rd_val;

	// operand mux
	always_comb begin
		case (op_i.origin)
			exec_pkg::ORIG_RS1_IMM: begin
				s1_alu = op_i.rs1;
				s2_alu = op_i.imm;
			end
			exec_pkg::ORIG_PC_IMM: begin
				s1_alu = op_i.pc;
				s2_alu = op_i.imm;
			end
			// regs and the unused code
			default: begin
				s1_alu = op_i.rs1;
				s2_alu = op_i.rs2;
			end
		endcase
	end

	exec_alu u_alu (
		.alu_op_i (op_i.alu_op),
		.a_i      (s1_alu),
		.b_i      (s2_alu),
		.result_o (alu_res),
		.zero_o   (alu_zero)
	);

	// store value is always rs2, address from the alu
	exec_lsu u_lsu (
		.lsu_op_i     (op_i.lsu_op),
		.addr_i       (alu_res),
		.store_val_i  (op_i.rs2),
		.load_word_i  (load_word_i),
		.adr_o        (wb_adr_o),
		.store_dat_o  (wb_dat_o),
		.sel_o        (wb_sel_o),
		.we_o         (wb_we_o),
		.access_o     (access_o),
		.misaligned_o (misaligned_o),
		.load_val_o   (mem_val)
	);

	exec_branch u_branch (
		.br_op_i      (op_i.br_op),
		.pc_i         (op_i.pc),
		.imm_i        (op_i.imm),
		.alu_result_i (alu_res),
		.alu_zero_i   (alu_zero),
		.pc_4_o       (pc_4),
		.next_pc_o    (next_pc),
		.taken_o      (taken)
	);

	// write-back mux
	always_comb begin
		case (op_i.target)
			exec_pkg::TGT_MEM: rd_val = mem_val;
			exec_pkg::TGT_PC_4: rd_val = pc_4;
			// csr value passes through untouched
			exec_pkg::TGT_CSR: rd_val = op_i.csr_val;
			default: rd_val = alu_res;
		endcase
	end

	always_comb begin
		res_o.rd_val = rd_val;
		res_o.next_pc = next_pc;
		res_o.taken = taken;
		res_o.bus_err = bus_err_i;
	end

endmodule

/* verilog/exec_ctrl_fsm.sv */
`timescale 1ns/1ps

module exec_ctrl_fsm (
	input logic clk_i,
	input logic rst_i,
	input logic op_valid_i,
	input logic access_i,
	input logic misaligned_i,
	input logic wb_ack_i,
	input logic wb_err_i,
	input logic timer_expired_i,
	output logic op_ready_o,
	output logic op_load_o,
	output logic timer_start_o,
	output logic timer_en_o,
	output logic bus_active_o,
	output logic data_capture_o,
	output logic bus_err_o,
	output logic res_valid_o
);

	exec_pkg::exec_state_e state_q;
	exec_pkg::exec_state_e state_d;
	// bus cycle closes on any of these
	logic bus_done;
	logic err_hit;

	assign bus_done = wb_ack_i || wb_err_i || timer_expired_i;
	// ack in the expiry cycle still counts as a good transfer
	assign err_hit = wb_err_i || (timer_expired_i && !wb_ack_i);

	always_comb begin
		state_d = state_q;
		case (state_q)
			exec_pkg::ST_IDLE: if (op_valid_i) state_d = exec_pkg::ST_EXEC;
			exec_pkg::ST_EXEC: begin
				// misaligned access skips the bus entirely
				if (access_i && !misaligned_i) state_d = exec_pkg::ST_BUS;
				else state_d = exec_pkg::ST_RESP;
			end
			exec_pkg::ST_BUS: if (bus_done) state_d = exec_pkg::ST_RESP;
			default: state_d = exec_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= exec_pkg::ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	assign op_ready_o = (state_q == exec_pkg::ST_IDLE);
	assign op_load_o = op_ready_o && op_valid_i;
	// counter cleared on the edge into bus
	assign timer_start_o = (state_q == exec_pkg::ST_EXEC) && access_i && !misaligned_i;
	assign bus_active_o = (state_q == exec_pkg::ST_BUS);
	assign timer_en_o = bus_active_o;
	assign data_capture_o = bus_active_o && wb_ack_i && !wb_err_i;
	assign res_valid_o = (state_q == exec_pkg::ST_RESP);

	// sticky until the next accepted op
	always_ff @(posedge clk_i) begin
		if (rst_i || op_load_o) begin
			bus_err_o <= 1'b0;
		end else if (state_q == exec_pkg::ST_EXEC && access_i && misaligned_i) begin
			bus_err_o <= 1'b1;
		end else if (bus_active_o && err_hit) begin
			bus_err_o <= 1'b1;
		end
	end

endmodule

/* verilog/exec_bus_timer.sv */
`timescale 1ns/1ps

module exec_bus_timer (
	input logic clk_i,
	input logic rst_i,
	input logic start_i,
	input logic en_i,
	output logic expired_o
);

	logic [exec_pkg::TIMER_WIDTH-1:0] count_q;

	// last bus cycle allowed
	assign expired_o = (count_q == exec_pkg::TIMER_WIDTH'(exec_pkg::BUS_TIMEOUT_CYCLES - 1));

	always_ff @(posedge clk_i) begin
		if (rst_i || start_i) begin
			count_q <= '0;
		end else if (en_i && !expired_o) begin
			// saturates at the limit
			count_q <= count_q + 1'b1;
		end
	end

endmodule

/* verilog/exec_top.sv */
`timescale 1ns/1ps

module exec_top (
	input logic clk_i,
	input logic rst_i,
	input logic op_valid_i,
	input exec_pkg::exec_op_t op_i,
	output logic op_ready_o,
	output logic res_valid_o,
	output exec_pkg::exec_res_t res_o,
	output exec_pkg::wb_req_t wb_o,
	input exec_pkg::data_t wb_dat_i,
	input logic wb_ack_i,
	input logic wb_err_i
);

	// held copy of the accepted op
	exec_pkg::exec_op_t op_q;
	// read data latched on ack
	exec_pkg::data_t load_word_q;
	logic op_load;
	logic access;
	logic misaligned;
	logic timer_start;
	logic timer_en;
	logic timer_expired;
	logic bus_active;
	logic data_capture;
	logic bus_err;
	exec_pkg::addr_t dp_adr;
	exec_pkg::data_t dp_dat;
	exec_pkg::sel_t dp_sel;
	logic dp_we;

	always_ff @(posedge clk_i) begin
		if (op_load) op_q <= op_i;
		if (data_capture) load_word_q <= wb_dat_i;
	end

	exec_ctrl_fsm u_fsm (
		.clk_i           (clk_i),
		.rst_i           (rst_i),
		.op_valid_i      (op_valid_i),
		.access_i        (access),
		.misaligned_i    (misaligned),
		.wb_ack_i        (wb_ack_i),
		.wb_err_i        (wb_err_i),
		.timer_expired_i (timer_expired),
		.op_ready_o      (op_ready_o),
		.op_load_o       (op_load),
		.timer_start_o   (timer_start),
		.timer_en_o      (timer_en),
		.bus_active_o    (bus_active),
		.data_capture_o  (data_capture),
		.bus_err_o       (bus_err),
		.res_valid_o     (res_valid_o)
	);

	exec_bus_timer u_timer (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.start_i   (timer_start),
		.en_i      (timer_en),
		.expired_o (timer_expired)
	);

	exec_datapath u_datapath (
		.op_i         (op_q),
		.load_word_i  (load_word_q),
		.bus_err_i    (bus_err),
		.wb_adr_o     (dp_adr),
		.wb_dat_o     (dp_dat),
		.wb_sel_o     (dp_sel),
		.wb_we_o      (dp_we),
		.access_o     (access),
		.misaligned_o (misaligned),
		.res_o        (res_o)
	);

	// cyc and stb only in bus, the rest follows the held op
	always_comb begin
		wb_o.cyc = bus_active;
		wb_o.stb = bus_active;
		wb_o.we = dp_we;
		wb_o.adr = dp_adr;
		wb_o.dat = dp_dat;
		wb_o.sel = dp_sel;
	end

endmodule

/* verif/exec_tb_clk.sv */
`timescale 1ns/1ps

module exec_tb_clk (
	output logic clk_o,
	output logic rst_o
);

	// 100 ns period
	initial begin
		clk_o = 1'b0;
		forever #50 clk_o = ~clk_o;
	end

	// reset held for 16 rising edges, released just after an edge
	initial begin
		rst_o = 1'b1;
		repeat (16) @(posedge clk_o);
		#5;
		rst_o = 1'b0;
	end

endmodule

/* verif/exec_tb_sva.sv */
`timescale 1ns/1ps

module exec_tb_sva (
	input logic clk_i,
	input logic rst_i,
	input logic op_ready_i,
	input logic res_valid_i,
	input exec_pkg::wb_req_t wb_i,
	input logic wb_ack_i,
	input logic wb_err_i
);

	// failed assertions, read back by the testbench
	int fail_count = 0;

	stb_needs_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_i.stb |-> wb_i.cyc)
		else begin
			$error("wishbone stb high without cyc");
			fail_count++;
		end

	// result is a single-cycle pulse
	res_valid_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
		res_valid_i |=> !res_valid_i)
		else begin
			$error("res_valid high for more than one cycle");
			fail_count++;
		end

	idle_no_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
		op_ready_i |-> !wb_i.cyc)
		else begin
			$error("cyc high while ready for a new op");
			fail_count++;
		end

	// request held until ack or err, a timeout may still drop cyc
	req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
		wb_i.cyc && !wb_ack_i && !wb_err_i |=> !wb_i.cyc || $stable(wb_i))
		else begin
			$error("wishbone request changed before ack or err");
			fail_count++;
		end

endmodule

bind exec_top exec_tb_sva u_sva (
	.clk_i       (clk_i),
	.rst_i       (rst_i),
	.op_ready_i  (op_ready_o),
	.res_valid_i (res_valid_o),
	.wb_i        (wb_o),
	.wb_ack_i    (wb_ack_i),
	.wb_err_i    (wb_err_i)
);

/* verif/exec_tb.sv */
`timescale 1ns/1ps

module exec_tb;

	logic clk_i;
	logic rst_i;
	logic op_valid_i;
	exec_pkg::exec_op_t op_i;
	logic op_ready_o;
	logic res_valid_o;
	exec_pkg::exec_res_t res_o;
	exec_pkg::wb_req_t wb_o;
	exec_pkg::data_t wb_dat_i;
	logic wb_ack_i;
	logic wb_err_i;

	// memory seen by the dut, and the model's copy
	exec_pkg::data_t mem [256];
	exec_pkg::data_t shadow [256];
	// bus request expected for the op in flight
	exec_pkg::addr_t exp_adr;
	exec_pkg::sel_t exp_sel;
	exec_pkg::data_t exp_dat;
	logic exp_we;
	logic exp_misaligned;
	string test_name;
	int wait_left = -1;
	int cyc_cycles = 0;
	int mismatches = 0;
	int failures = 0;
	// ops per test
	int alu_runs = 60;
	int branch_runs = 40;
	int mem_runs = 60;
	int misaligned_runs = 12;
	int silent_runs = 6;
	int err_runs = 6;

	exec_tb_clk u_clk (
		.clk_o (clk_i),
		.rst_o (rst_i)
	);

	exec_top u_dut (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.op_valid_i  (op_valid_i),
		.op_i        (op_i),
		.op_ready_o  (op_ready_o),
		.res_valid_o (res_valid_o),
		.res_o       (res_o),
		.wb_o        (wb_o),
		.wb_dat_i    (wb_dat_i),
		.wb_ack_i    (wb_ack_i),
		.wb_err_i    (wb_err_i)
	);

	// top 16 words never answer
	function automatic bit is_silent(input int word);
		return word >= 240;
	endfunction

	// the one word that answers with err
	function automatic bit is_err_word(input int word);
		return word == 100;
	endfunction

	function automatic int access_bytes(input exec_pkg::lsu_op_e lsu);
		case (lsu)
			exec_pkg::LSU_LB, exec_pkg::LSU_LBU, exec_pkg::LSU_SB: return 1;
			exec_pkg::LSU_LH, exec_pkg::LSU_LHU, exec_pkg::LSU_SH: return 2;
			exec_pkg::LSU_LW, exec_pkg::LSU_SW: return 4;
			default: return 0;
		endcase
	endfunction

	function automatic bit is_store(input exec_pkg::lsu_op_e lsu);
		return lsu inside {exec_pkg::LSU_SB, exec_pkg::LSU_SH, exec_pkg::LSU_SW};
	endfunction

	task automatic report_mismatch(input string what, input exec_pkg::data_t exp,
		input exec_pkg::data_t act);
		mismatches++;
		$display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
	endtask

	// busy from accept until the result is out
	task automatic check_not_ready();
		assert (!op_ready_o) else begin
			failures++;
			$display("%s: ready for a new op while one is in flight", test_name);
		end
	endtask

	// isa rules applied to the op, loads read the shadow copy
	task automatic predict(input exec_pkg::exec_op_t op, output exec_pkg::exec_res_t res);
		exec_pkg::data_t a;
		exec_pkg::data_t b;
		exec_pkg::data_t alu;
		exec_pkg::data_t ld;
		exec_pkg::data_t target;
		logic [4:0] sh;
		int idx;
		int off;
		int size;
		a = (op.origin == exec_pkg::ORIG_PC_IMM) ? op.pc : op.rs1;
		b = (op.origin == exec_pkg::ORIG_REGS) ? op.rs2 : op.imm;
		sh = b[4:0];
		case (op.alu_op)
			exec_pkg::ALU_ADD: alu = a + b;
			exec_pkg::ALU_SUB: alu = a - b;
			exec_pkg::ALU_SLL: alu = a << sh;
			exec_pkg::ALU_SLT: alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			exec_pkg::ALU_SLTU: alu = (a < b) ? 32'd1 : 32'd0;
			exec_pkg::ALU_XOR: alu = a ^ b;
			exec_pkg::ALU_SRL: alu = a >> sh;
			// logical shift with the vacated bits filled from the sign
			exec_pkg::ALU_SRA: alu = (a >> sh) | (a[31] ? ~(32'hffffffff >> sh) : 32'd0);
			exec_pkg::ALU_OR: alu = a | b;
			exec_pkg::ALU_AND: alu = a & b;
			default: alu = b;
		endcase
		idx = alu[9:2];
		off = alu[1:0];
		size = access_bytes(op.lsu_op);
		ld = shadow[idx] >> (8 * off);
		case (op.lsu_op)
			exec_pkg::LSU_LB: ld = {{24{ld[7]}}, ld[7:0]};
			exec_pkg::LSU_LBU: ld = {24'd0, ld[7:0]};
			exec_pkg::LSU_LH: ld = {{16{ld[15]}}, ld[15:0]};
			exec_pkg::LSU_LHU: ld = {16'd0, ld[15:0]};
			default: ld = shadow[idx];
		endcase
		// bus side of the access
		exp_adr = alu[9:0] & ~10'h3;
		exp_we = is_store(op.lsu_op);
		exp_sel = (size == 4) ? 4'hf : (size == 2) ? (4'h3 << off) : (4'h1 << off);
		exp_dat = (size == 4) ? op.rs2 : (size == 2) ? ((op.rs2 & 32'hffff) << (8 * off)) :
			((op.rs2 & 32'hff) << (8 * off));
		exp_misaligned = (size == 2 && off[0]) || (size == 4 && off != 0);
		res.bus_err = (size != 0) && (exp_misaligned || is_silent(idx) || is_err_word(idx));
		case (op.br_op)
			exec_pkg::BR_JAL, exec_pkg::BR_JALR: res.taken = 1'b1;
			exec_pkg::BR_ZERO: res.taken = (alu == 0);
			exec_pkg::BR_NONZERO: res.taken = (alu != 0);
			default: res.taken = 1'b0;
		endcase
		target = (op.br_op == exec_pkg::BR_JALR) ? (alu & ~32'd1) : op.pc + op.imm;
		res.next_pc = res.taken ? target : op.pc + 4;
		case (op.target)
			exec_pkg::TGT_MEM: res.rd_val = ld;
			exec_pkg::TGT_PC_4: res.rd_val = op.pc + 4;
			exec_pkg::TGT_CSR: res.rd_val = op.csr_val;
			default: res.rd_val = alu;
		endcase
	endtask

	// compared on the ack cycle, only lanes in sel carry data
	task automatic check_request();
		exec_pkg::data_t mask;
		mask = {{8{exp_sel[3]}}, {8{exp_sel[2]}}, {8{exp_sel[1]}}, {8{exp_sel[0]}}};
		assert (wb_o.adr == exp_adr) else report_mismatch("bus address", exp_adr, wb_o.adr);
		assert (wb_o.sel == exp_sel) else report_mismatch("bus sel", exp_sel, wb_o.sel);
		assert (wb_o.we == exp_we) else report_mismatch("bus we", exp_we, wb_o.we);
		if (exp_we) begin
			assert ((wb_o.dat & mask) == exp_dat)
				else report_mismatch("store data", exp_dat, wb_o.dat & mask);
		end
	endtask

	// wishbone slave, 0 to 3 wait states per access
	always @(posedge clk_i) begin
		int word;
		#5;
		wb_ack_i = 1'b0;
		wb_err_i = 1'b0;
		word = wb_o.adr[9:2];
		if (!wb_o.cyc || !wb_o.stb) begin
			wait_left = -1;
		end else begin
			cyc_cycles++;
			if (wait_left < 0) wait_left = $urandom % 4;
			if (wait_left > 0) begin
				wait_left--;
			end else if (is_err_word(word)) begin
				wb_err_i = 1'b1;
			end else if (!is_silent(word)) begin
				wb_ack_i = 1'b1;
				check_request();
				wb_dat_i = mem[word];
				for (int l = 0; l < 4; l++) begin
					if (wb_o.we && wb_o.sel[l]) mem[word][8*l +: 8] = wb_o.dat[8*l +: 8];
				end
			end
		end
	end

	// random operands, no memory access and no branch
	function automatic exec_pkg::exec_op_t random_fields();
		exec_pkg::exec_op_t op;
		op.alu_op = exec_pkg::ALU_ADD;
		op.lsu_op = exec_pkg::LSU_NONE;
		op.br_op = exec_pkg::BR_NONE;
		op.origin = exec_pkg::ORIG_REGS;
		op.target = exec_pkg::TGT_ALU;
		op.rs1 = $urandom;
		op.rs2 = $urandom;
		op.imm = $urandom;
		op.pc = $urandom & ~32'd3;
		op.csr_val = $urandom;
		return op;
	endfunction

	function automatic exec_pkg::exec_op_t random_alu_op();
		exec_pkg::exec_op_t op;
		op = random_fields();
		op.alu_op = exec_pkg::alu_op_e'($urandom % 11);
		op.origin = exec_pkg::origin_e'($urandom % 3);
		case ($urandom % 3)
			0: op.target = exec_pkg::TGT_ALU;
			1: op.target = exec_pkg::TGT_PC_4;
			default: op.target = exec_pkg::TGT_CSR;
		endcase
		return op;
	endfunction

	function automatic exec_pkg::exec_op_t random_branch();
		exec_pkg::exec_op_t op;
		op = random_fields();
		op.target = exec_pkg::TGT_PC_4;
		case ($urandom % 4)
			0: begin
				op.br_op = exec_pkg::BR_JAL;
				op.origin = exec_pkg::ORIG_PC_IMM;
			end
			1: begin
				op.br_op = exec_pkg::BR_JALR;
				op.origin = exec_pkg::ORIG_RS1_IMM;
			end
			default: begin
				op.br_op = ($urandom % 2) ? exec_pkg::BR_ZERO : exec_pkg::BR_NONZERO;
				op.target = exec_pkg::TGT_ALU;
				case ($urandom % 3)
					0: op.alu_op = exec_pkg::ALU_SUB;
					1: op.alu_op = exec_pkg::ALU_SLT;
					default: op.alu_op = exec_pkg::ALU_SLTU;
				endcase
				// equal operands so that beq style compares hit
				if ($urandom % 4 == 0) op.rs2 = op.rs1;
			end
		endcase
		return op;
	endfunction

	// kind 0 aligned, 1 misaligned, 2 silent region, 3 err word
	function automatic exec_pkg::exec_op_t random_mem_op(input int kind);
		exec_pkg::exec_op_t op;
		exec_pkg::lsu_op_e lsu;
		logic [11:0] r;
		int size;
		int word;
		int off;
		op = random_fields();
		lsu = exec_pkg::lsu_op_e'(1 + $urandom % 8);
		case (kind)
			0: word = $urandom % 240;
			1: word = $urandom % 240;
			2: word = 240 + $urandom % 16;
			default: word = 100;
		endcase
		if (kind == 0 && is_err_word(word)) word++;
		// bytes are never misaligned
		if (kind == 1 && access_bytes(lsu) == 1) begin
			lsu = ($urandom % 2) ? exec_pkg::LSU_SH : exec_pkg::LSU_LW;
		end
		size = access_bytes(lsu);
		if (kind == 1) off = (size == 2) ? 1 + 2 * ($urandom % 2) : 1 + $urandom % 3;
		else off = ($urandom % (4 / size)) * size;
		r = $urandom;
		op.imm = {{20{r[11]}}, r};
		// rs1 chosen so that rs1 + imm lands on the wanted byte
		op.rs1 = ((($urandom) & ~32'h3ff) | (word << 2) | off) - op.imm;
		op.lsu_op = lsu;
		op.origin = exec_pkg::ORIG_RS1_IMM;
		op.target = is_store(lsu) ? exec_pkg::TGT_ALU : exec_pkg::TGT_MEM;
		return op;
	endfunction

	// issue one op, wait for its result and compare with the model
	task automatic run_op(input string name, input exec_pkg::exec_op_t op);
		exec_pkg::exec_res_t exp;
		int edges;
		int idx;
		test_name = name;
		predict(op, exp);
		idx = exp_adr[9:2];
		while (!op_ready_o) begin
			@(posedge clk_i);
			#5;
		end
		cyc_cycles = 0;
		op_valid_i = 1'b1;
		op_i = op;
		@(posedge clk_i);
		#5;
		op_valid_i = 1'b0;
		edges = 1;
		while (!res_valid_o) begin
			check_not_ready();
			@(posedge clk_i);
			#5;
			edges++;
		end
		check_not_ready();
		assert (res_o.bus_err == exp.bus_err)
			else report_mismatch("bus_err", exp.bus_err, res_o.bus_err);
		assert (res_o.taken == exp.taken)
			else report_mismatch("taken", exp.taken, res_o.taken);
		assert (res_o.next_pc == exp.next_pc)
			else report_mismatch("next_pc", exp.next_pc, res_o.next_pc);
		// a failed load leaves no defined value
		if (!(exp.bus_err && op.target == exec_pkg::TGT_MEM)) begin
			assert (res_o.rd_val == exp.rd_val)
				else report_mismatch("rd_val", exp.rd_val, res_o.rd_val);
		end
		if (op.lsu_op == exec_pkg::LSU_NONE) begin
			assert (edges == 2) else report_mismatch("result latency", 2, edges);
		end else begin
			if (is_store(op.lsu_op) && !exp.bus_err) begin
				for (int l = 0; l < 4; l++) begin
					if (exp_sel[l]) shadow[idx][8*l +: 8] = exp_dat[8*l +: 8];
				end
			end
			assert (mem[idx] == shadow[idx])
				else report_mismatch("memory word", shadow[idx], mem[idx]);
		end
		assert (!exp_misaligned || cyc_cycles == 0) else begin
			failures++;
			$display("%s: a bus cycle started for a misaligned access", test_name);
		end
		assert (cyc_cycles <= exec_pkg::BUS_TIMEOUT_CYCLES) else begin
			failures++;
			$display("%s: bus cycle lasted %0d cycles, longer than the timeout", test_name,
				cyc_cycles);
		end
	endtask

	initial begin
		void'($urandom(32'h6e5f0d75));
		op_valid_i = 1'b0;
		op_i = '0;
		wb_dat_i = '0;
		wb_ack_i = 1'b0;
		wb_err_i = 1'b0;
		// fill depends on every address bit
		for (int i = 0; i < 256; i++) begin
			mem[i] = (i * 32'h01010101) ^ (i << 20) ^ 32'ha5c30f96;
			shadow[i] = mem[i];
		end
		@(negedge rst_i);
		test_name = "reset";
		repeat (4) begin
			@(posedge clk_i);
			#5;
			assert (op_ready_o && !res_valid_o && !wb_o.cyc) else begin
				failures++;
				$display("reset state wrong: ready %b, res_valid %b, cyc %b", op_ready_o,
					res_valid_o, wb_o.cyc);
			end
		end
		repeat (alu_runs) run_op("alu", random_alu_op());
		repeat (branch_runs) run_op("branch", random_branch());
		repeat (mem_runs) run_op("aligned memory", random_mem_op(0));
		repeat (misaligned_runs) run_op("misaligned", random_mem_op(1));
		repeat (silent_runs) run_op("silent region", random_mem_op(2));
		repeat (err_runs) run_op("err word", random_mem_op(3));
		test_name = "final memory";
		for (int i = 0; i < 256; i++) begin
			assert (mem[i] == shadow[i]) else report_mismatch("word", shadow[i], mem[i]);
		end
		failures += u_dut.u_sva.fail_count;
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// reset plus a full bus timeout and some overhead for each op
	initial begin
		#((16 + (alu_runs + branch_runs + mem_runs + misaligned_runs + silent_runs + err_runs)
			* (exec_pkg::BUS_TIMEOUT_CYCLES + 8)) * 100);
		$display("timeout: the run did not finish in the expected time");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* all.f */
verilog/exec_pkg.sv
verilog/exec_alu.sv
verilog/exec_lsu.sv
verilog/exec_branch.sv
verilog/exec_datapath.sv
verilog/exec_ctrl_fsm.sv
verilog/exec_bus_timer.sv
verilog/exec_top.sv
verif/exec_tb_clk.sv
verif/exec_tb_sva.sv
verif/exec_tb.sv

/* Bender.yml */
package:
  name: exec_stage

sources:
  - files:
      - verilog/exec_pkg.sv
      - verilog/exec_alu.sv
      - verilog/exec_lsu.sv
      - verilog/exec_branch.sv
      - verilog/exec_datapath.sv
      - verilog/exec_ctrl_fsm.sv
      - verilog/exec_bus_timer.sv
      - verilog/exec_top.sv
  - target: test
    files:
      - verif/exec_tb_clk.sv
      - verif/exec_tb_sva.sv
      - verif/exec_tb.sv
